// File: include/clint_macros.svh
// clint parameters: bus widths, register map and mtime tick divider
`ifndef CLINT_MACROS_SVH
`define CLINT_MACROS_SVH

// bus geometry
`define CLINT_ADDR_W 32
`define CLINT_DATA_W 64
`define CLINT_ID_W 4

// register map
`define CLINT_BASE 32'h0200_0000
`define CLINT_MSIP_OFS 32'h0000_0000
`define CLINT_MTIMECMP_OFS 32'h0000_4000
`define CLINT_MTIME_OFS 32'h0000_bff8

// clocks per mtime increment
`define CLINT_TICK_DIV 4

`endif

// File: design/clint_bus_pkg.sv
// clint bus types, response codes and strobe expansion
`include "clint_macros.svh"

package clint_bus_pkg;

  typedef logic [`CLINT_ADDR_W-1:0] bus_addr_t;
  typedef logic [`CLINT_DATA_W-1:0] bus_data_t;
  typedef logic [`CLINT_DATA_W/8-1:0] bus_strb_t;
  typedef logic [`CLINT_ID_W-1:0] bus_id_t;
  typedef logic [1:0] bus_resp_t;

  localparam bus_resp_t RESP_OKAY = 2'd0;
  localparam bus_resp_t RESP_DECERR = 2'd3;

  // one strobe bit widened to a byte lane of ones
  function automatic bus_data_t strb_to_mask(input bus_strb_t strb);
    bus_data_t mask;
    for (int i = 0; i < `CLINT_DATA_W / 8; i++) begin
      mask[8*i +: 8] = {8{strb[i]}};
    end
    return mask;
  endfunction

endpackage

// File: design/clint_reg_pkg.sv
// clint register-side types: register select and register word

package clint_reg_pkg;

  // all three registers are 64 bits wide in the memory map
  typedef logic [63:0] reg_word_t;

  typedef enum logic [1:0] {
    SEL_NONE,
    SEL_MSIP,
    SEL_MTIMECMP,
    SEL_MTIME
  } reg_sel_e;

endpackage

// File: design/clint_csr_if.sv
// clint register access bundle from bus controller to timer and csr bank
`timescale 1ns/1ns

interface clint_csr_if;
  import clint_bus_pkg::*;
  import clint_reg_pkg::*;

  reg_sel_e rd_sel;
  reg_sel_e wr_sel;
  logic wr_en;
  reg_word_t wr_data;
  bus_strb_t wr_strb;
  reg_word_t rd_data;

  modport ctrl (
    output rd_sel,
    output wr_sel,
    output wr_en,
    output wr_data,
    output wr_strb,
    input  rd_data
  );

  modport bank (
    input  rd_sel,
    input  wr_sel,
    input  wr_en,
    input  wr_data,
    input  wr_strb,
    output rd_data
  );

  // mtime itself goes to the bank on a plain port
  modport timer (
    input  wr_sel,
    input  wr_en,
    input  wr_data,
    input  wr_strb
  );

endinterface

// File: design/clint_bus_ctrl.sv
// clint bus controller: AXI read and write FSMs, address decode, responses
`timescale 1ns/1ns
`include "clint_macros.svh"

module clint_bus_ctrl (
  input  logic                     clk,
  input  logic                     rst,

  input  logic                     aw_valid_i,
  input  clint_bus_pkg::bus_addr_t aw_addr_i,
  input  clint_bus_pkg::bus_id_t   aw_id_i,
  output logic                     aw_ready_o,

  input  logic                     w_valid_i,
  input  clint_bus_pkg::bus_data_t w_data_i,
  input  clint_bus_pkg::bus_strb_t w_strb_i,
  output logic                     w_ready_o,

  input  logic                     b_ready_i,
  output logic                     b_valid_o,
  output clint_bus_pkg::bus_resp_t b_resp_o,
  output clint_bus_pkg::bus_id_t   b_id_o,

  input  logic                     ar_valid_i,
  input  clint_bus_pkg::bus_addr_t ar_addr_i,
  input  clint_bus_pkg::bus_id_t   ar_id_i,
  output logic                     ar_ready_o,

  input  logic                     r_ready_i,
  output logic                     r_valid_o,
  output clint_bus_pkg::bus_data_t r_data_o,
  output clint_bus_pkg::bus_resp_t r_resp_o,
  output clint_bus_pkg::bus_id_t   r_id_o,

  clint_csr_if.ctrl                csr
);
  import clint_bus_pkg::*;
  import clint_reg_pkg::*;

  typedef enum logic {
    R_IDLE,
    R_RESP
  } rd_state_e;

  typedef enum logic [1:0] {
    W_IDLE,
    W_DATA,
    W_RESP
  } wr_state_e;

  rd_state_e rd_state_q;
  wr_state_e wr_state_q;

  bus_addr_t wr_addr_q;
  logic wr_decerr_q;
  bus_id_t wr_id_q;

  bus_data_t r_data_q;
  bus_resp_t r_resp_q;
  bus_id_t r_id_q;

  logic ar_hs;
  logic r_hs;
  logic aw_hs;
  logic w_hs;
  logic b_hs;

  // exact match on base plus offset, 8-byte aligned only
  function automatic reg_sel_e decode(input bus_addr_t addr);
    reg_sel_e sel;
    sel = SEL_NONE;
    if (addr[2:0] == 3'b000) begin
      if (addr == bus_addr_t'(`CLINT_BASE + `CLINT_MSIP_OFS)) begin
        sel = SEL_MSIP;
      end else if (addr == bus_addr_t'(`CLINT_BASE + `CLINT_MTIMECMP_OFS)) begin
        sel = SEL_MTIMECMP;
      end else if (addr == bus_addr_t'(`CLINT_BASE + `CLINT_MTIME_OFS)) begin
        sel = SEL_MTIME;
      end
    end
    return sel;
  endfunction

  assign ar_hs = ar_valid_i && ar_ready_o;
  assign r_hs = r_valid_o && r_ready_i;
  assign aw_hs = aw_valid_i && aw_ready_o;
  assign w_hs = w_valid_i && w_ready_o;
  assign b_hs = b_valid_o && b_ready_i;

  // read side
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_state_q <= R_IDLE;
    end else begin
      case (rd_state_q)
        R_IDLE: if (ar_hs) rd_state_q <= R_RESP;
        R_RESP: if (r_hs) rd_state_q <= R_IDLE;
        default: rd_state_q <= R_IDLE;
      endcase
    end
  end

  // select straight from AR so the data is captured on the handshake
  assign csr.rd_sel = decode(ar_addr_i);

  always_ff @(posedge clk) begin
    if (ar_hs) begin
      r_data_q <= csr.rd_data;
      r_resp_q <= (csr.rd_sel == SEL_NONE) ? RESP_DECERR : RESP_OKAY;
      r_id_q <= ar_id_i;
    end
  end

  assign ar_ready_o = (rd_state_q == R_IDLE);
  assign r_valid_o = (rd_state_q == R_RESP);
  assign r_data_o = r_data_q;
  assign r_resp_o = r_resp_q;
  assign r_id_o = r_id_q;

  // write side
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_state_q <= W_IDLE;
    end else begin
      case (wr_state_q)
        W_IDLE: if (aw_hs) wr_state_q <= W_DATA;
        W_DATA: if (w_hs) wr_state_q <= W_RESP;
        W_RESP: if (b_hs) wr_state_q <= W_IDLE;
        default: wr_state_q <= W_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) begin
      wr_addr_q <= aw_addr_i;
      wr_decerr_q <= (decode(aw_addr_i) == SEL_NONE);
      wr_id_q <= aw_id_i;
    end
  end

  assign aw_ready_o = (wr_state_q == W_IDLE);
  assign w_ready_o = (wr_state_q == W_DATA);
  assign b_valid_o = (wr_state_q == W_RESP);
  assign b_resp_o = wr_decerr_q ? RESP_DECERR : RESP_OKAY;
  assign b_id_o = wr_id_q;

  // register update lands on the W edge
  assign csr.wr_sel = decode(wr_addr_q);
  assign csr.wr_en = w_hs && !wr_decerr_q;
  assign csr.wr_data = w_data_i;
  assign csr.wr_strb = w_strb_i;

  a_r_hold: assert property (@(posedge clk) disable iff (rst)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable({r_data_o, r_resp_o, r_id_o}));

  a_b_hold: assert property (@(posedge clk) disable iff (rst)
    b_valid_o && !b_ready_i |=> b_valid_o);

  // error flag latched at AW must agree with the decode of the held address
  a_wr_mapped: assert property (@(posedge clk) disable iff (rst)
    csr.wr_en |-> csr.wr_sel != SEL_NONE);

endmodule

// File: design/clint_timer.sv
// clint timer: mtime prescaler and counter, timer interrupt compare
`timescale 1ns/1ns
`include "clint_macros.svh"

module clint_timer (
  input  logic                     clk,
  input  logic                     rst,
  clint_csr_if.timer               csr,
  input  clint_reg_pkg::reg_word_t mtimecmp_i,
  output clint_reg_pkg::reg_word_t mtime_o,
  output logic                     irq_timer_o
);
  import clint_bus_pkg::*;
  import clint_reg_pkg::*;

  localparam int unsigned DIV_W = $clog2(`CLINT_TICK_DIV);

  logic [DIV_W-1:0] tick_cnt_q;
  logic tick;
  logic mtime_wr;
  bus_data_t wr_mask;
  reg_word_t mtime_q;

  assign tick = (tick_cnt_q == DIV_W'(`CLINT_TICK_DIV - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      tick_cnt_q <= '0;
    end else if (tick) begin
      tick_cnt_q <= '0;
    end else begin
      tick_cnt_q <= tick_cnt_q + 1'b1;
    end
  end

  assign mtime_wr = csr.wr_en && (csr.wr_sel == SEL_MTIME);
  assign wr_mask = strb_to_mask(csr.wr_strb);

  // bus write wins over the tick
  always_ff @(posedge clk) begin
    if (rst) begin
      mtime_q <= '0;
    end else if (mtime_wr) begin
      mtime_q <= (mtime_q & ~wr_mask) | (csr.wr_data & wr_mask);
    end else if (tick) begin
      mtime_q <= mtime_q + 1'b1;
    end
  end

  assign mtime_o = mtime_q;
  assign irq_timer_o = (mtime_q >= mtimecmp_i);

  // without a write mtime holds or steps by one
  a_mtime_mono: assert property (@(posedge clk) disable iff (rst)
    !mtime_wr |=> (mtime_q == $past(mtime_q)) || (mtime_q == $past(mtime_q) + 1'b1));

endmodule

// File: design/clint_csr_bank.sv
// clint csr bank: msip and mtimecmp storage, readback mux, software interrupt
`timescale 1ns/1ns

module clint_csr_bank (
  input  logic                     clk,
  input  logic                     rst,
  clint_csr_if.bank                csr,
  input  clint_reg_pkg::reg_word_t mtime_i,
  output clint_reg_pkg::reg_word_t mtimecmp_o,
  output logic                     irq_soft_o
);
  import clint_bus_pkg::*;
  import clint_reg_pkg::*;

  logic msip_q;
  reg_word_t mtimecmp_q;
  bus_data_t wr_mask;
  logic msip_wr;
  logic mtimecmp_wr;

  assign wr_mask = strb_to_mask(csr.wr_strb);
  assign msip_wr = csr.wr_en && (csr.wr_sel == SEL_MSIP);
  assign mtimecmp_wr = csr.wr_en && (csr.wr_sel == SEL_MTIMECMP);

  // only bit 0 of msip is kept
  always_ff @(posedge clk) begin
    if (rst) begin
      msip_q <= 1'b0;
    end else if (msip_wr) begin
      msip_q <= (msip_q & ~wr_mask[0]) | (csr.wr_data[0] & wr_mask[0]);
    end
  end

  // all ones keeps the timer interrupt quiet out of reset
  always_ff @(posedge clk) begin
    if (rst) begin
      mtimecmp_q <= '1;
    end else if (mtimecmp_wr) begin
      mtimecmp_q <= (mtimecmp_q & ~wr_mask) | (csr.wr_data & wr_mask);
    end
  end

  always_comb begin
    case (csr.rd_sel)
      SEL_MSIP:     csr.rd_data = reg_word_t'(msip_q);
      SEL_MTIMECMP: csr.rd_data = mtimecmp_q;
      SEL_MTIME:    csr.rd_data = mtime_i;
      default:      csr.rd_data = '0;
    endcase
  end

  assign mtimecmp_o = mtimecmp_q;
  assign irq_soft_o = msip_q;

endmodule

// File: design/clint_top.sv
// clint top: AXI slave with msip, mtimecmp and mtime, soft and timer interrupts
`timescale 1ns/1ns

module clint_top (
  input  logic                     clk,
  input  logic                     rst,

  input  logic                     aw_valid_i,
  input  clint_bus_pkg::bus_addr_t aw_addr_i,
  input  clint_bus_pkg::bus_id_t   aw_id_i,
  output logic                     aw_ready_o,

  input  logic                     w_valid_i,
  input  clint_bus_pkg::bus_data_t w_data_i,
  input  clint_bus_pkg::bus_strb_t w_strb_i,
  output logic                     w_ready_o,

  input  logic                     b_ready_i,
  output logic                     b_valid_o,
  output clint_bus_pkg::bus_resp_t b_resp_o,
  output clint_bus_pkg::bus_id_t   b_id_o,

  input  logic                     ar_valid_i,
  input  clint_bus_pkg::bus_addr_t ar_addr_i,
  input  clint_bus_pkg::bus_id_t   ar_id_i,
  output logic                     ar_ready_o,

  input  logic                     r_ready_i,
  output logic                     r_valid_o,
  output clint_bus_pkg::bus_data_t r_data_o,
  output clint_bus_pkg::bus_resp_t r_resp_o,
  output clint_bus_pkg::bus_id_t   r_id_o,

  output logic                     irq_soft_o,
  output logic                     irq_timer_o
);
  import clint_reg_pkg::*;

  reg_word_t mtime;
  reg_word_t mtimecmp;

  clint_csr_if csr_if_i ();

  clint_bus_ctrl bus_ctrl_i (
    .clk        (clk),
    .rst        (rst),
    .aw_valid_i (aw_valid_i),
    .aw_addr_i  (aw_addr_i),
    .aw_id_i    (aw_id_i),
    .aw_ready_o (aw_ready_o),
    .w_valid_i  (w_valid_i),
    .w_data_i   (w_data_i),
    .w_strb_i   (w_strb_i),
    .w_ready_o  (w_ready_o),
    .b_ready_i  (b_ready_i),
    .b_valid_o  (b_valid_o),
    .b_resp_o   (b_resp_o),
    .b_id_o     (b_id_o),
    .ar_valid_i (ar_valid_i),
    .ar_addr_i  (ar_addr_i),
    .ar_id_i    (ar_id_i),
    .ar_ready_o (ar_ready_o),
    .r_ready_i  (r_ready_i),
    .r_valid_o  (r_valid_o),
    .r_data_o   (r_data_o),
    .r_resp_o   (r_resp_o),
    .r_id_o     (r_id_o),
    .csr        (csr_if_i.ctrl)
  );

  clint_timer timer_i (
    .clk         (clk),
    .rst         (rst),
    .csr         (csr_if_i.timer),
    .mtimecmp_i  (mtimecmp),
    .mtime_o     (mtime),
    .irq_timer_o (irq_timer_o)
  );

  clint_csr_bank csr_bank_i (
    .clk        (clk),
    .rst        (rst),
    .csr        (csr_if_i.bank),
    .mtime_i    (mtime),
    .mtimecmp_o (mtimecmp),
    .irq_soft_o (irq_soft_o)
  );

endmodule

// File: testbench/clint_tb.sv
// clint testbench: table-driven AXI register checks, mtime and interrupt tests
`timescale 1ns/1ns
`include "clint_macros.svh"

module clint_tb;
  import clint_bus_pkg::*;

  localparam bus_addr_t MSIP_ADDR = `CLINT_BASE + `CLINT_MSIP_OFS;
  localparam bus_addr_t MTIMECMP_ADDR = `CLINT_BASE + `CLINT_MTIMECMP_OFS;
  localparam bus_addr_t MTIME_ADDR = `CLINT_BASE + `CLINT_MTIME_OFS;

  typedef struct {
    bit        is_wr;
    bus_addr_t addr;
    bus_data_t data;
    bus_strb_t strb;
    bus_data_t exp_data;
    bus_resp_t exp_resp;
    logic      exp_soft;
    bit        chk_data;
  } row_t;

  logic clk;
  logic rst;
  logic aw_valid, w_valid, b_ready, ar_valid, r_ready;
  bus_addr_t aw_addr, ar_addr;
  bus_id_t aw_id, ar_id;
  bus_data_t w_data;
  bus_strb_t w_strb;
  logic aw_ready_o, w_ready_o, b_valid_o, ar_ready_o, r_valid_o;
  bus_resp_t b_resp_o, r_resp_o;
  bus_id_t b_id_o, r_id_o;
  bus_data_t r_data_o;
  logic irq_soft_o, irq_timer_o;

  row_t rows[$];
  logic model_msip;
  bus_data_t model_mtimecmp;
  bus_id_t next_id;
  int cycles;
  int timeout_cycles;
  int mismatches;
  int failures;

  clint_top clint_top_i (
    .clk(clk), .rst(rst),
    .aw_valid_i(aw_valid), .aw_addr_i(aw_addr), .aw_id_i(aw_id), .aw_ready_o(aw_ready_o),
    .w_valid_i(w_valid), .w_data_i(w_data), .w_strb_i(w_strb), .w_ready_o(w_ready_o),
    .b_ready_i(b_ready), .b_valid_o(b_valid_o), .b_resp_o(b_resp_o), .b_id_o(b_id_o),
    .ar_valid_i(ar_valid), .ar_addr_i(ar_addr), .ar_id_i(ar_id), .ar_ready_o(ar_ready_o),
    .r_ready_i(r_ready), .r_valid_o(r_valid_o), .r_data_o(r_data_o), .r_resp_o(r_resp_o),
    .r_id_o(r_id_o),
    .irq_soft_o(irq_soft_o), .irq_timer_o(irq_timer_o)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("timeout: run did not finish within %0d cycles", timeout_cycles);
      $display("mismatches: %0d, other failures: %0d", mismatches, failures + 1);
      $display("Simulation FAILED");
      $finish;
    end
  end

  task automatic compare(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      mismatches++;
      $display("mismatch at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  // byte lanes with a strobe take the new data
  function automatic bus_data_t merge_bytes(input bus_data_t old_v, input bus_data_t new_v,
                                            input bus_strb_t strb);
    bus_data_t res;
    res = old_v;
    for (int b = 0; b < 8; b++) begin
      if (strb[b]) res[8*b +: 8] = new_v[8*b +: 8];
    end
    return res;
  endfunction

  // 0 unmapped, 1 msip, 2 mtimecmp, 3 mtime
  function automatic int reg_of(input bus_addr_t addr);
    if (addr == MSIP_ADDR) return 1;
    if (addr == MTIMECMP_ADDR) return 2;
    if (addr == MTIME_ADDR) return 3;
    return 0;
  endfunction

  task automatic add_write(input bus_addr_t addr, input bus_data_t data, input bus_strb_t strb);
    row_t row;
    int sel;
    sel = reg_of(addr);
    if (sel == 1 && strb[0]) model_msip = data[0];
    if (sel == 2) model_mtimecmp = merge_bytes(model_mtimecmp, data, strb);
    row.is_wr = 1'b1;
    row.addr = addr;
    row.data = data;
    row.strb = strb;
    row.exp_data = '0;
    row.exp_resp = (sel == 0) ? RESP_DECERR : RESP_OKAY;
    row.exp_soft = model_msip;
    row.chk_data = 1'b0;
    rows.push_back(row);
  endtask

  task automatic add_read(input bus_addr_t addr);
    row_t row;
    int sel;
    sel = reg_of(addr);
    row.is_wr = 1'b0;
    row.addr = addr;
    row.data = '0;
    row.strb = '0;
    row.exp_data = (sel == 1) ? {63'b0, model_msip} : (sel == 2) ? model_mtimecmp : '0;
    row.exp_resp = (sel == 0) ? RESP_DECERR : RESP_OKAY;
    row.exp_soft = model_msip;
    row.chk_data = (sel != 3);
    rows.push_back(row);
  endtask

  task automatic bus_write(input bus_addr_t addr, input bus_data_t data, input bus_strb_t strb,
                           output bus_resp_t resp, output int w_edge);
    int stall;
    bus_id_t id;
    id = next_id++;
    @(negedge clk);
    aw_valid = 1'b1;
    aw_addr = addr;
    aw_id = id;
    while (!aw_ready_o) @(negedge clk);
    @(negedge clk);
    aw_valid = 1'b0;
    // idle AW payload is don't care
    aw_addr = ~addr;
    aw_id = ~id;
    w_valid = 1'b1;
    w_data = data;
    w_strb = strb;
    while (!w_ready_o) @(negedge clk);
    w_edge = cycles;
    @(negedge clk);
    w_valid = 1'b0;
    stall = $urandom_range(0, 3);
    while (!b_valid_o) @(negedge clk);
    repeat (stall) begin
      @(negedge clk);
      if (!b_valid_o) begin
        failures++;
        $display("bvalid dropped before the B transfer at %0t ns", $time);
      end
    end
    b_ready = 1'b1;
    resp = b_resp_o;
    compare(b_id_o, id, "b id");
    @(negedge clk);
    b_ready = 1'b0;
  endtask

  task automatic bus_read(input bus_addr_t addr, input int min_stall, output bus_data_t data,
                          output bus_resp_t resp, output int r_edge);
    int stall;
    bus_id_t id;
    bus_data_t held_data;
    bus_resp_t held_resp;
    bus_id_t held_id;
    id = next_id++;
    @(negedge clk);
    ar_valid = 1'b1;
    ar_addr = addr;
    ar_id = id;
    while (!ar_ready_o) @(negedge clk);
    @(negedge clk);
    ar_valid = 1'b0;
    // idle AR payload is don't care
    ar_addr = ~addr;
    ar_id = ~id;
    stall = min_stall + $urandom_range(0, 3);
    while (!r_valid_o) @(negedge clk);
    held_data = r_data_o;
    held_resp = r_resp_o;
    held_id = r_id_o;
    repeat (stall) begin
      @(negedge clk);
      if (!r_valid_o) begin
        failures++;
        $display("rvalid dropped before the R transfer at %0t ns", $time);
      end
      compare(r_data_o, held_data, "r data while stalled");
      compare(r_resp_o, held_resp, "r resp while stalled");
      compare(r_id_o, held_id, "r id while stalled");
    end
    r_ready = 1'b1;
    data = r_data_o;
    resp = r_resp_o;
    r_edge = cycles;
    compare(r_id_o, id, "r id");
    @(negedge clk);
    r_ready = 1'b0;
  endtask

  initial begin
    bus_resp_t resp;
    bus_data_t rdata;
    bus_data_t rdata2;
    bus_data_t v;
    int w_edge;
    int r_edge;
    int r_edge2;
    int waited;

    void'($urandom(32'hcfa2ac7e));
    clk = 1'b0;
    rst = 1'b1;
    {aw_valid, w_valid, b_ready, ar_valid, r_ready} = '0;
    aw_addr = '0;
    ar_addr = '0;
    aw_id = '0;
    ar_id = '0;
    w_data = '0;
    w_strb = '0;
    next_id = '0;
    cycles = 0;
    mismatches = 0;
    failures = 0;
    model_msip = 1'b0;
    model_mtimecmp = '1;

    // reset values, msip bit 0 and strobe handling
    add_read(MSIP_ADDR);
    add_read(MTIMECMP_ADDR);
    add_write(MSIP_ADDR, 64'hffff_ffff_ffff_fffe, 8'hff);
    add_read(MSIP_ADDR);
    add_write(MSIP_ADDR, 64'h1, 8'h01);
    add_read(MSIP_ADDR);
    add_write(MSIP_ADDR, 64'h0, 8'hfe);
    add_read(MSIP_ADDR);
    add_write(MSIP_ADDR, 64'h0, 8'h01);
    add_read(MSIP_ADDR);
    // partial mtimecmp writes
    add_write(MTIMECMP_ADDR, 64'h3c5a_91e7_0b24_d86f, 8'h0f);
    add_write(MTIMECMP_ADDR, 64'h7e19_c4b2_58f0_a3d6, 8'ha5);
    add_write(MTIMECMP_ADDR, 64'h92d7_1f6e_c08b_4a35, 8'h30);
    add_read(MTIMECMP_ADDR);
    add_write(MTIMECMP_ADDR, 64'h1b8e_f340_6d27_95ca, 8'h81);
    add_read(MTIMECMP_ADDR);
    // unmapped and misaligned accesses
    add_read(`CLINT_BASE + 32'h8);
    add_read(MTIMECMP_ADDR + 32'h4);
    add_read(32'h0300_0000);
    add_write(MTIMECMP_ADDR + 32'h4, 64'h0, 8'hff);
    add_write(MSIP_ADDR + 32'h4, 64'h1, 8'hff);
    add_read(MSIP_ADDR);
    add_read(MTIMECMP_ADDR);
    timeout_cycles = rows.size() * 40 + 200;

    repeat (10) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    compare(irq_soft_o, 1'b0, "irq_soft after reset");
    compare(irq_timer_o, 1'b0, "irq_timer after reset");
    compare(ar_ready_o, 1'b1, "ar_ready after reset");
    compare(aw_ready_o, 1'b1, "aw_ready after reset");
    compare(w_ready_o, 1'b0, "w_ready after reset");
    compare(r_valid_o, 1'b0, "r_valid after reset");
    compare(b_valid_o, 1'b0, "b_valid after reset");

    foreach (rows[i]) begin
      if (rows[i].is_wr) begin
        bus_write(rows[i].addr, rows[i].data, rows[i].strb, resp, w_edge);
      end else begin
        bus_read(rows[i].addr, 0, rdata, resp, r_edge);
        if (rows[i].chk_data) compare(rdata, rows[i].exp_data, $sformatf("row %0d data", i));
      end
      compare(resp, rows[i].exp_resp, $sformatf("row %0d resp", i));
      compare(irq_soft_o, rows[i].exp_soft, $sformatf("row %0d irq_soft", i));
    end

    // mtime advances at most one step per four clocks
    v = 64'h0000_0001_0000_0000;
    bus_write(MTIME_ADDR, v, 8'hff, resp, w_edge);
    bus_read(MTIME_ADDR, 0, rdata, resp, r_edge);
    if (rdata < v || rdata > v + 64'((r_edge - w_edge) / 4) + 1) begin
      failures++;
      $display("mtime %0h out of range after write of %0h", rdata, v);
    end
    bus_read(MTIME_ADDR, 0, rdata2, resp, r_edge2);
    if (rdata2 < rdata) begin
      failures++;
      $display("mtime decreased from %0h to %0h", rdata, rdata2);
    end

    // timer interrupt
    v = 64'h100;
    bus_write(MTIME_ADDR, v, 8'hff, resp, w_edge);
    bus_write(MTIMECMP_ADDR, v + 20, 8'hff, resp, w_edge);
    compare(irq_timer_o, 1'b0, "irq_timer before compare match");
    waited = 0;
    while (!irq_timer_o && waited < 100) begin
      @(negedge clk);
      waited++;
    end
    if (!irq_timer_o) begin
      failures++;
      $display("timer interrupt not raised within 100 clocks");
    end
    bus_write(MTIMECMP_ADDR, '1, 8'hff, resp, w_edge);
    compare(irq_timer_o, 1'b0, "irq_timer after mtimecmp all ones");

    // misaligned mtime write must not touch mtime
    bus_read(MTIME_ADDR, 0, rdata, resp, r_edge);
    bus_write(MTIME_ADDR + 32'h4, 64'hffff_0000_0000_0000, 8'hff, resp, w_edge);
    compare(resp, RESP_DECERR, "misaligned mtime write resp");
    bus_read(MTIME_ADDR, 0, rdata2, resp, r_edge2);
    if (rdata2 < rdata || rdata2 > rdata + 64'((r_edge2 - r_edge) / 4) + 1) begin
      failures++;
      $display("mtime changed by a DECERR write, %0h then %0h", rdata, rdata2);
    end

    // long rready stall
    bus_read(MTIMECMP_ADDR, 6, rdata, resp, r_edge);
    compare(rdata, '1, "mtimecmp under rready stall");
    compare(resp, RESP_OKAY, "resp under rready stall");

    $display("mismatches: %0d, other failures: %0d", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: compile.f
+incdir+include
design/clint_bus_pkg.sv
design/clint_reg_pkg.sv
design/clint_csr_if.sv
design/clint_bus_ctrl.sv
design/clint_timer.sv
design/clint_csr_bank.sv
design/clint_top.sv
testbench/clint_tb.sv
